// File: hw/nlc_pkg.sv
`default_nettype none

package nlc_pkg;

	//////////////////////////////////////////////////
	// Sizes and fixed-point format
	//////////////////////////////////////////////////

	localparam int WORD_W       = 32;
	localparam int FRAC_W       = 16; // Q16.16
	localparam int SAMPLE_W     = 21;
	localparam int LIMIT_W      = 20; // Unsigned magnitude
	localparam int ORDER        = 10;
	localparam int NUM_COEFF    = ORDER + 1;
	localparam int NUM_SECTIONS = 4;
	localparam int CFG_WORDS    = NUM_COEFF + 2; // Coefficients, mean, reciprocal
	localparam int APB_ADDR_W   = 12;

	typedef logic signed [WORD_W-1:0]   word_t;
	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic [1:0]                 section_t;
	typedef logic [3:0]                 word_idx_t;

	// Word indices within a section
	localparam word_idx_t NEG_MEAN_IDX = 4'd11;
	localparam word_idx_t RECIP_IDX    = 4'd12;

	localparam logic [APB_ADDR_W-1:0] LIMIT_ADDR = 12'h100;

	// Section codes, code 0 is section 1
	localparam section_t SEC_1 = 2'd0; // x <= 0, |x| > limit
	localparam section_t SEC_2 = 2'd1; // x <= 0, |x| <= limit
	localparam section_t SEC_3 = 2'd2; // x > 0, |x| <= limit
	localparam section_t SEC_4 = 2'd3; // x > 0, |x| > limit

	// Output clamp bounds
	localparam word_t SAT_MAX = word_t'((1 <<< (SAMPLE_W - 1)) - 1);
	localparam word_t SAT_MIN = -word_t'(1 <<< (SAMPLE_W - 1));

	typedef enum logic [2:0] {
		IDLE,
		SUM,
		SCALE,
		HORNER,
		EMIT
	} seq_state_e;

	typedef enum logic [2:0] {
		OP_NONE,
		OP_SUM,
		OP_SCALE,
		OP_HORNER,
		OP_EMIT
	} dp_op_e;

endpackage

`default_nettype wire

// File: hw/nlc_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module nlc_apb_regs
	import nlc_pkg::*;
(
	input  wire                   srdyi,
	input  wire                   srdyo,
	input  wire                   i_psel,
	input  wire                   i_penable,
	input  wire                   i_pwrite,
	input  wire  [APB_ADDR_W-1:0] i_paddr,
	input  word_t                 i_pwdata,
	output word_t                 o_prdata,
	output logic                  o_pready,
	output logic                  o_pslverr,
	input  section_t              i_rd_section,
	input  word_idx_t             i_rd_word,
	output word_t                 o_rd_data,
	output logic [LIMIT_W-1:0]    o_limit
);

	word_t              cfg_q [NUM_SECTIONS][CFG_WORDS];
	logic [LIMIT_W-1:0] limit_q;

	section_t  a_section;
	word_idx_t a_word;
	logic      coeff_hit;
	logic      limit_hit;
	logic      access;

	//////////////////////////////////////////////////
	// Address decode
	//////////////////////////////////////////////////

	// section x 64 + word x 4
	assign a_section = i_paddr[7:6];
	assign a_word    = i_paddr[5:2];

	assign coeff_hit = (i_paddr[APB_ADDR_W-1:8] == '0) &&
		(i_paddr[1:0] == 2'b00) && (a_word <= RECIP_IDX);
	assign limit_hit = (i_paddr == LIMIT_ADDR);

	assign access = i_psel && i_penable;

	assign o_pready  = 1'b1; // No wait states
	assign o_pslverr = access && !(coeff_hit || limit_hit);

	//////////////////////////////////////////////////
	// Register storage
	//////////////////////////////////////////////////

	always_ff @(posedge srdyi or posedge srdyo) begin
		if (srdyo) begin
			for (int s = 0; s < NUM_SECTIONS; s++) begin
				for (int w = 0; w < CFG_WORDS; w++) begin
					cfg_q[s][w] <= '0;
				end
			end
			limit_q <= '0;
		end else if (access && i_pwrite) begin
			if (coeff_hit) begin
				cfg_q[a_section][a_word] <= i_pwdata;
			end
			if (limit_hit) begin
				limit_q <= i_pwdata[LIMIT_W-1:0];
			end
		end
	end

	// Bus read mux with zero for unmapped reads
	always_comb begin
		o_prdata = '0;
		if (i_psel && !i_pwrite) begin
			if (coeff_hit) begin
				o_prdata = cfg_q[a_section][a_word];
			end else if (limit_hit) begin
				o_prdata = word_t'({{(WORD_W-LIMIT_W){1'b0}}, limit_q});
			end
		end
	end

	// Engine read mux
	always_comb begin
		if (i_rd_word <= RECIP_IDX) begin
			o_rd_data = cfg_q[i_rd_section][i_rd_word];
		end else begin
			o_rd_data = '0; // Holes at 13..15
		end
	end

	assign o_limit = limit_q;

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Error response only in the access phase that follows a setup phase
	a_slverr_access: assert property (@(posedge srdyi) disable iff (srdyo)
		o_pslverr |-> (i_penable && $past(i_psel && !i_penable)))
		else $error("pslverr outside access phase");

endmodule

`default_nettype wire

// File: hw/nlc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module nlc_sequencer
	import nlc_pkg::*;
(
	input  wire                srdyi,
	input  wire                srdyo,
	input  wire                i_sample_valid,
	input  sample_t            i_sample,
	input  wire  [LIMIT_W-1:0] i_limit,
	output logic               o_sample_ready,
	output logic               o_result_valid,
	output section_t           o_rd_section,
	output word_idx_t          o_rd_word,
	output dp_op_e             o_op,
	output sample_t            o_sample
);

	seq_state_e state_q;
	word_idx_t  cnt_q;     // Horner word counting 10 down to 0
	section_t   section_q;
	sample_t    sample_q;

	logic [SAMPLE_W-1:0] mag;
	logic                is_pos;
	logic                over;
	section_t            section_d;
	logic                accept;

	//////////////////////////////////////////////////
	// Section decision
	//////////////////////////////////////////////////

	// -2^20 still fits as an unsigned 21-bit magnitude
	assign mag    = i_sample[SAMPLE_W-1] ? SAMPLE_W'(-i_sample) : SAMPLE_W'(i_sample);
	assign is_pos = !i_sample[SAMPLE_W-1] && (i_sample != '0);
	assign over   = mag > {1'b0, i_limit};

	always_comb begin
		case ({is_pos, over})
			2'b11:   section_d = SEC_4;
			2'b10:   section_d = SEC_3;
			2'b00:   section_d = SEC_2;
			default: section_d = SEC_1;
		endcase
	end

	assign o_sample_ready = (state_q == IDLE);
	assign accept         = i_sample_valid && o_sample_ready;

	//////////////////////////////////////////////////
	// Control FSM
	//////////////////////////////////////////////////

	always_ff @(posedge srdyi or posedge srdyo) begin
		if (srdyo) begin
			state_q        <= IDLE;
			cnt_q          <= '0;
			section_q      <= SEC_1;
			o_result_valid <= 1'b0;
		end else begin
			o_result_valid <= 1'b0;
			case (state_q)
				IDLE: begin
					if (accept) begin
						section_q <= section_d; // Fixed for the whole sample
						state_q   <= SUM;
					end
				end
				SUM:   state_q <= SCALE;
				SCALE: begin
					cnt_q   <= word_idx_t'(ORDER);
					state_q <= HORNER;
				end
				HORNER: begin
					if (cnt_q == '0) begin
						state_q <= EMIT;
					end else begin
						cnt_q <= cnt_q - 1'b1;
					end
				end
				EMIT: begin
					o_result_valid <= 1'b1; // Result register loads at the same edge
					state_q        <= IDLE;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge srdyi) begin
		if (accept) begin
			sample_q <= i_sample;
		end
	end

	// Word select and opcode per state
	always_comb begin
		case (state_q)
			SUM:     o_rd_word = NEG_MEAN_IDX;
			SCALE:   o_rd_word = RECIP_IDX;
			HORNER:  o_rd_word = cnt_q;
			default: o_rd_word = '0;
		endcase
	end

	always_comb begin
		case (state_q)
			SUM:     o_op = OP_SUM;
			SCALE:   o_op = OP_SCALE;
			HORNER:  o_op = OP_HORNER;
			EMIT:    o_op = OP_EMIT;
			default: o_op = OP_NONE;
		endcase
	end

	assign o_rd_section = section_q;
	assign o_sample     = sample_q;

	a_valid_pulse: assert property (@(posedge srdyi) disable iff (srdyo)
		o_result_valid |=> !o_result_valid)
		else $error("result valid held two cycles");

	// An idle cycle leads to SUM only on acceptance
	a_idle_op: assert property (@(posedge srdyi) disable iff (srdyo)
		(state_q == IDLE) |=> (o_op == ($past(accept) ? OP_SUM : OP_NONE)))
		else $error("datapath op issued while idle");

endmodule

`default_nettype wire

// File: hw/nlc_horner_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module nlc_horner_datapath
	import nlc_pkg::*;
(
	input  wire     srdyi,
	input  wire     srdyo,
	input  dp_op_e  i_op,
	input  sample_t i_sample,
	input  word_t   i_coeff,
	output sample_t o_result
);

	word_t acc_q; // Centred sum, then the Horner accumulator
	word_t t_q;   // Scaled variable

	word_t                      x_ext;
	word_t                      mul_b;
	logic signed [2*WORD_W-1:0] prod;
	word_t                      prod_q;
	word_t                      add_a;
	word_t                      sum;
	sample_t                    sat;

	//////////////////////////////////////////////////
	// Shared multiply-add
	//////////////////////////////////////////////////

	assign x_ext = {{(WORD_W-SAMPLE_W){i_sample[SAMPLE_W-1]}}, i_sample};

	// Reciprocal during SCALE, t during the Horner loop
	assign mul_b  = (i_op == OP_SCALE) ? i_coeff : t_q;
	assign prod   = acc_q * mul_b;
	assign prod_q = prod[FRAC_W +: WORD_W]; // Arithmetic shift by 16, truncate

	assign add_a = (i_op == OP_SUM) ? x_ext : prod_q;
	assign sum   = add_a + i_coeff; // Wraps at 32 bits

	// Clamp to the signed 21-bit range
	always_comb begin
		if (acc_q > SAT_MAX) begin
			sat = sample_t'(SAT_MAX);
		end else if (acc_q < SAT_MIN) begin
			sat = sample_t'(SAT_MIN);
		end else begin
			sat = sample_t'(acc_q);
		end
	end

	always_ff @(posedge srdyi or posedge srdyo) begin
		if (srdyo) begin
			acc_q    <= '0;
			t_q      <= '0;
			o_result <= '0;
		end else begin
			case (i_op)
				OP_SUM:    acc_q <= sum; // x + negative mean
				OP_SCALE: begin
					t_q   <= prod_q;
					acc_q <= '0; // Horner starts from zero
				end
				OP_HORNER: acc_q <= sum;
				OP_EMIT:   o_result <= sat;
				default: ;
			endcase
		end
	end

	a_t_stable: assert property (@(posedge srdyi) disable iff (srdyo)
		(i_op != OP_SCALE) |=> $stable(t_q))
		else $error("t changed outside SCALE");

endmodule

`default_nettype wire

// File: hw/nlc_top.sv
`timescale 1ns/1ps
`default_nettype none

module nlc_top
	import nlc_pkg::*;
(
	input  wire                  srdyi,
	input  wire                  srdyo,
	// APB
	input  wire                  i_psel,
	input  wire                  i_penable,
	input  wire                  i_pwrite,
	input  wire [APB_ADDR_W-1:0] i_paddr,
	input  word_t                i_pwdata,
	output word_t                o_prdata,
	output logic                 o_pready,
	output logic                 o_pslverr,
	// Sample in, result out
	input  wire                  i_sample_valid,
	input  sample_t              i_sample,
	output logic                 o_sample_ready,
	output logic                 o_result_valid,
	output sample_t              o_result
);

	section_t           rd_section;
	word_idx_t          rd_word;
	word_t              rd_data;
	logic [LIMIT_W-1:0] limit;
	dp_op_e             op;
	sample_t            sample_q;

	nlc_apb_regs u_regs (
		.srdyi        (srdyi),
		.srdyo        (srdyo),
		.i_psel       (i_psel),
		.i_penable    (i_penable),
		.i_pwrite     (i_pwrite),
		.i_paddr      (i_paddr),
		.i_pwdata     (i_pwdata),
		.o_prdata     (o_prdata),
		.o_pready     (o_pready),
		.o_pslverr    (o_pslverr),
		.i_rd_section (rd_section),
		.i_rd_word    (rd_word),
		.o_rd_data    (rd_data),
		.o_limit      (limit)
	);

	nlc_sequencer u_seq (
		.srdyi          (srdyi),
		.srdyo          (srdyo),
		.i_sample_valid (i_sample_valid),
		.i_sample       (i_sample),
		.i_limit        (limit),
		.o_sample_ready (o_sample_ready),
		.o_result_valid (o_result_valid),
		.o_rd_section   (rd_section),
		.o_rd_word      (rd_word),
		.o_op           (op),
		.o_sample       (sample_q)
	);

	// Coefficient word goes straight from the register file
	nlc_horner_datapath u_dp (
		.srdyi    (srdyi),
		.srdyo    (srdyo),
		.i_op     (op),
		.i_sample (sample_q),
		.i_coeff  (rd_data),
		.o_result (o_result)
	);

endmodule

`default_nettype wire

// File: dv/nlc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module nlc_tb
	import nlc_pkg::*;
();

	localparam int SETTLE         = 2;    // Drive delay after the rising edge
	localparam int DONE_EDGE      = 14;   // Acceptance to result pulse
	localparam int TIMEOUT_CYCLES = 5000; // Tests need about 1300 cycles
	localparam int RES_MAX        = (1 << (SAMPLE_W - 1)) - 1;
	localparam int RES_MIN        = -(1 << (SAMPLE_W - 1));

	logic                  srdyi;
	logic                  srdyo;
	logic                  i_psel;
	logic                  i_penable;
	logic                  i_pwrite;
	logic [APB_ADDR_W-1:0] i_paddr;
	word_t                 i_pwdata;
	word_t                 o_prdata;
	logic                  o_pready;
	logic                  o_pslverr;
	logic                  i_sample_valid;
	sample_t               i_sample;
	logic                  o_sample_ready;
	logic                  o_result_valid;
	sample_t               o_result;

	// Shadow of the register file, kept by the APB tasks
	word_t              shadow_cfg [NUM_SECTIONS][CFG_WORDS];
	logic [LIMIT_W-1:0] shadow_limit;
	word_t              exp_rdata;
	logic               exp_slverr;

	logic    pending;      // Sample in flight
	int      since_accept; // Edges since acceptance
	sample_t exp_result;
	int      accepted_cnt;
	int      result_cnt;
	int      sent_cnt;
	int      cycle_cnt = 0;
	integer  seed;

	nlc_top dut (
		.srdyi          (srdyi),
		.srdyo          (srdyo),
		.i_psel         (i_psel),
		.i_penable      (i_penable),
		.i_pwrite       (i_pwrite),
		.i_paddr        (i_paddr),
		.i_pwdata       (i_pwdata),
		.o_prdata       (o_prdata),
		.o_pready       (o_pready),
		.o_pslverr      (o_pslverr),
		.i_sample_valid (i_sample_valid),
		.i_sample       (i_sample),
		.o_sample_ready (o_sample_ready),
		.o_result_valid (o_result_valid),
		.o_result       (o_result)
	);

	always #20 srdyi = ~srdyi;

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "simulation stopped at first error");
	endtask

	always @(posedge srdyi) begin
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			stop_with_failure($sformatf("Timeout: tests still running after %0d cycles",
				cycle_cnt));
		end else begin
			cycle_cnt <= cycle_cnt + 1;
		end
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic sample_t model_result(input sample_t smp);
		int     v;
		int     mag;
		int     sec;
		int     k;
		word_t  s;
		word_t  t;
		word_t  acc;
		longint p;
		v   = smp;
		mag = (v < 0) ? -v : v;
		if (v > 0) begin
			sec = (mag > int'(shadow_limit)) ? 3 : 2;
		end else begin
			sec = (mag > int'(shadow_limit)) ? 0 : 1;
		end
		s   = word_t'(v) + shadow_cfg[sec][NEG_MEAN_IDX]; // Centre
		p   = longint'(s) * longint'(shadow_cfg[sec][RECIP_IDX]);
		t   = word_t'(p >>> FRAC_W);
		acc = '0;
		for (k = ORDER; k >= 0; k--) begin
			p   = longint'(acc) * longint'(t);
			acc = word_t'(p >>> FRAC_W) + shadow_cfg[sec][k];
		end
		if (acc > RES_MAX) begin
			return sample_t'(RES_MAX);
		end else if (acc < RES_MIN) begin
			return sample_t'(RES_MIN);
		end
		return sample_t'(acc);
	endfunction

	function automatic logic coeff_addr(input logic [APB_ADDR_W-1:0] a);
		return (a < LIMIT_ADDR) && (a[1:0] == 2'b00) && (a[5:2] <= RECIP_IDX);
	endfunction

	function automatic logic [APB_ADDR_W-1:0] cfg_addr(input int sec, input int word);
		return APB_ADDR_W'(sec * 64 + word * 4);
	endfunction

	// Tracks acceptance and the expected result
	always @(posedge srdyi or posedge srdyo) begin
		if (srdyo) begin
			pending      <= 1'b0;
			since_accept <= 0;
			exp_result   <= '0;
			accepted_cnt <= 0;
			result_cnt   <= 0;
		end else begin
			if (o_result_valid) result_cnt <= result_cnt + 1;
			if (i_sample_valid && o_sample_ready) begin
				pending      <= 1'b1;
				since_accept <= 0;
				exp_result   <= model_result(i_sample);
				accepted_cnt <= accepted_cnt + 1;
			end else if (pending) begin
				since_accept <= since_accept + 1;
				if (o_result_valid) pending <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// Checks, sampled mid-cycle
	//////////////////////////////////////////////////

	a_pready: assert property (@(negedge srdyi) disable iff (srdyo) o_pready)
		else stop_with_failure($sformatf("[FAIL] %0t: pready low", $time));

	a_rdata: assert property (@(negedge srdyi) disable iff (srdyo)
		(i_psel && i_penable && !i_pwrite) |-> (o_prdata == exp_rdata))
		else stop_with_failure($sformatf("[FAIL] %0t: read 0x%03h gave 0x%08h, expected 0x%08h",
			$time, i_paddr, o_prdata, exp_rdata));

	a_slverr: assert property (@(negedge srdyi) disable iff (srdyo)
		o_pslverr == (i_psel && i_penable && exp_slverr))
		else stop_with_failure($sformatf("[FAIL] %0t: pslverr %0b at address 0x%03h",
			$time, o_pslverr, i_paddr));

	a_valid_timing: assert property (@(negedge srdyi) disable iff (srdyo)
		o_result_valid == (pending && since_accept == DONE_EDGE))
		else stop_with_failure($sformatf("[FAIL] %0t: result valid %0b, %0d edges after accept",
			$time, o_result_valid, since_accept));

	a_ready: assert property (@(negedge srdyi) disable iff (srdyo)
		o_sample_ready == !(pending && since_accept < DONE_EDGE))
		else stop_with_failure($sformatf("[FAIL] %0t: sample ready %0b, %0d edges after accept",
			$time, o_sample_ready, since_accept));

	a_result: assert property (@(negedge srdyi) disable iff (srdyo)
		o_result_valid |-> (o_result == exp_result))
		else stop_with_failure($sformatf("[FAIL] %0t: result %0d, expected %0d",
			$time, o_result, exp_result));

	//////////////////////////////////////////////////
	// Bus and sample tasks
	//////////////////////////////////////////////////

	// All tasks start and end SETTLE after a rising edge
	task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input word_t data);
		i_psel     = 1'b1;
		i_penable  = 1'b0;
		i_pwrite   = 1'b1;
		i_paddr    = addr;
		i_pwdata   = data;
		exp_slverr = !(coeff_addr(addr) || addr == LIMIT_ADDR);
		@(posedge srdyi);
		#SETTLE;
		i_penable = 1'b1;
		@(posedge srdyi); // Access edge
		#SETTLE;
		if (coeff_addr(addr)) begin
			shadow_cfg[addr[7:6]][addr[5:2]] = data;
		end else if (addr == LIMIT_ADDR) begin
			shadow_limit = data[LIMIT_W-1:0];
		end
		i_psel    = 1'b0;
		i_penable = 1'b0;
		i_pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [APB_ADDR_W-1:0] addr);
		i_psel     = 1'b1;
		i_penable  = 1'b0;
		i_pwrite   = 1'b0;
		i_paddr    = addr;
		exp_slverr = !(coeff_addr(addr) || addr == LIMIT_ADDR);
		if (coeff_addr(addr)) begin
			exp_rdata = shadow_cfg[addr[7:6]][addr[5:2]];
		end else if (addr == LIMIT_ADDR) begin
			exp_rdata = word_t'({{(WORD_W-LIMIT_W){1'b0}}, shadow_limit});
		end else begin
			exp_rdata = '0;
		end
		@(posedge srdyi);
		#SETTLE;
		i_penable = 1'b1;
		@(posedge srdyi);
		#SETTLE;
		i_psel    = 1'b0;
		i_penable = 1'b0;
	endtask

	task automatic send_sample(input sample_t smp);
		while (!o_sample_ready) begin
			@(posedge srdyi);
			#SETTLE;
		end
		i_sample_valid = 1'b1;
		i_sample       = smp;
		sent_cnt++;
		@(posedge srdyi);
		#SETTLE;
		i_sample_valid = 1'b0;
	endtask

	task automatic wait_result();
		while (!o_result_valid) begin
			@(posedge srdyi);
			#SETTLE;
		end
	endtask

	task automatic run_sample(input sample_t smp);
		send_sample(smp);
		wait_result();
	endtask

	// Small coefficients, 21-bit means, 8-bit reciprocals
	task automatic load_random_config();
		int    s;
		int    w;
		word_t r;
		for (s = 0; s < NUM_SECTIONS; s++) begin
			for (w = 0; w < CFG_WORDS; w++) begin
				r = $random(seed);
				if (w == NEG_MEAN_IDX) begin
					r = {{11{r[20]}}, r[20:0]};
				end else if (w == RECIP_IDX) begin
					r = {24'd0, r[7:0]};
				end else begin
					r = {{12{r[19]}}, r[19:0]};
				end
				apb_write(cfg_addr(s, w), r);
			end
		end
		r = $random(seed);
		apb_write(LIMIT_ADDR, r);
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin
		int    sec;
		int    w;
		int    n;
		word_t data;
		seed           = 32'hf8eced28;
		srdyi          = 1'b0;
		srdyo          = 1'b1;
		i_psel         = 1'b0;
		i_penable      = 1'b0;
		i_pwrite       = 1'b0;
		i_paddr        = '0;
		i_pwdata       = '0;
		i_sample_valid = 1'b0;
		i_sample       = '0;
		exp_rdata      = '0;
		exp_slverr     = 1'b0;
		sent_cnt       = 0;
		shadow_limit   = '0;
		for (sec = 0; sec < NUM_SECTIONS; sec++) begin
			for (w = 0; w < CFG_WORDS; w++) shadow_cfg[sec][w] = '0;
		end
		repeat (2) @(posedge srdyi);
		#SETTLE;
		srdyo = 1'b0;

		// Readback, words 13..15 are holes
		for (sec = 0; sec < NUM_SECTIONS; sec++) begin
			for (w = 0; w < 16; w++) begin
				data = $random(seed);
				apb_write(cfg_addr(sec, w), data);
				apb_read(cfg_addr(sec, w));
			end
		end
		data = $random(seed);
		apb_write(LIMIT_ADDR, data);
		apb_read(LIMIT_ADDR);
		apb_write(12'h104, data);
		apb_read(12'h104);
		apb_read(12'h002); // Misaligned
		apb_read(12'h200);

		// Section selection by coefficient 0 only
		for (sec = 0; sec < NUM_SECTIONS; sec++) begin
			for (w = 0; w < CFG_WORDS; w++) begin
				apb_write(cfg_addr(sec, w), (w == 0) ? word_t'(11 * (sec + 1)) : '0);
			end
		end
		apb_write(LIMIT_ADDR, 1000);
		run_sample(sample_t'(1005));
		run_sample(sample_t'(1000));
		run_sample(sample_t'(0));
		run_sample(sample_t'(-1000));
		run_sample(sample_t'(-1005));
		run_sample(sample_t'(RES_MIN)); // Largest magnitude

		// Full polynomial
		repeat (2) begin
			load_random_config();
			for (n = 0; n < 8; n++) begin
				data = $random(seed);
				run_sample(sample_t'(data));
			end
		end

		// Saturation both ways
		for (sec = 0; sec < NUM_SECTIONS; sec++) begin
			for (w = 0; w < CFG_WORDS; w++) apb_write(cfg_addr(sec, w), '0);
		end
		apb_write(cfg_addr(3, 0), 32'sh0100_0000);
		apb_write(cfg_addr(0, 0), -32'sh0100_0000);
		apb_write(LIMIT_ADDR, 100);
		run_sample(sample_t'(50000));
		run_sample(sample_t'(-50000));

		// Sample while busy is dropped, then back-to-back acceptance
		load_random_config();
		data = $random(seed);
		send_sample(sample_t'(data));
		repeat (3) begin
			@(posedge srdyi);
			#SETTLE;
		end
		i_sample_valid = 1'b1;
		i_sample       = sample_t'($random(seed));
		repeat (4) begin
			@(posedge srdyi);
			#SETTLE;
		end
		i_sample_valid = 1'b0;
		wait_result();
		data = $random(seed);
		run_sample(sample_t'(data)); // Accepted one edge after the pulse
		@(posedge srdyi);
		#SETTLE;

		if (accepted_cnt == sent_cnt && result_cnt == accepted_cnt) begin
			$display("All tests passed!");
			$finish;
		end else begin
			stop_with_failure($sformatf("Count mismatch: %0d sent, %0d accepted, %0d results",
				sent_cnt, accepted_cnt, result_cnt));
		end
	end

endmodule

`default_nettype wire

// File: tb.f
hw/nlc_pkg.sv
hw/nlc_apb_regs.sv
hw/nlc_sequencer.sv
hw/nlc_horner_datapath.sv
hw/nlc_top.sv
dv/nlc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the NLC testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal \
	--top-module nlc_tb -f tb.f --Mdir "$BUILD_DIR" -o nlc_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/nlc_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
